//--- common/hwpe_sub_cfg.svh
// ********************************************************************
// Widths, core count and register map of the accelerator subsystem
// Include in any RTL or testbench file that decodes control accesses
// ********************************************************************
`ifndef HWPE_SUB_CFG_SVH
`define HWPE_SUB_CFG_SVH

// Data word and memory word-address widths
`define HWPE_DW       32
`define HWPE_AW       16
`define HWPE_NR_CORES 4
// Bit 8 picks the engine, bits 7:0 hold the byte offset
`define HWPE_CTRL_AW  9

// Engine registers
`define REG_TRIGGER 8'h00
`define REG_STATUS  8'h04
`define REG_SRC     8'h08
`define REG_DST     8'h0C
`define REG_LEN     8'h10
`define REG_CORE    8'h14
`define REG_FACTOR  8'h18

// Subsystem registers
`define REG_EVT_CLR 8'h94
`define REG_MUX_SEL 8'h98
`define REG_ENABLE  8'h9C

`endif

//--- common/hwpe_sub_pkg.sv
// ********************************************************************
// Types shared by the engines, the router and the memory mux
// Import inside the module body where a type is needed
// ********************************************************************
package hwpe_sub_pkg;

  // Sequencer states of both engines
  typedef enum logic [2:0] {
    IDLE,
    READ,
    WAIT,
    WRITE,
    DONE
  } engine_state_e;

  // Picks one of the two engines
  typedef logic engine_idx_t;

endpackage

//--- source/hwpe_ctrl_router.sv
// ********************************************************************
// Control port decoder of the subsystem
// Owns the enable, mux select and event registers, forwards the rest
// ********************************************************************
`timescale 1ns/100ps
`include "hwpe_sub_cfg.svh"

module hwpe_ctrl_router (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        ctrl_req_i,
  input  logic                        ctrl_we_i,
  input  logic [`HWPE_CTRL_AW-1:0]    ctrl_addr_i,
  input  logic [`HWPE_DW-1:0]         ctrl_wdata_i,
  output logic                        ctrl_rvalid_o,
  output logic [`HWPE_DW-1:0]         ctrl_rdata_o,
  output logic [1:0]                  eng_req_o,
  output logic                        eng_we_o,
  output logic [`HWPE_CTRL_AW-2:0]    eng_addr_o,
  output logic [`HWPE_DW-1:0]         eng_wdata_o,
  input  logic [`HWPE_DW-1:0]         eng0_rdata_i,
  input  logic [`HWPE_DW-1:0]         eng1_rdata_i,
  input  logic [`HWPE_NR_CORES-1:0]   eng0_evt_i,
  input  logic [`HWPE_NR_CORES-1:0]   eng1_evt_i,
  output logic [1:0]                  eng_en_o,
  output hwpe_sub_pkg::engine_idx_t   mux_sel_o,
  output logic [`HWPE_NR_CORES-1:0]   hwpe_evt_o
);
  import hwpe_sub_pkg::*;

  localparam int unsigned DW      = `HWPE_DW;
  localparam int unsigned OfsW    = `HWPE_CTRL_AW - 1;
  localparam int unsigned NrCores = `HWPE_NR_CORES;

  logic [OfsW-1:0]    ofs;
  engine_idx_t        eng_sel;
  logic               sub_hit;
  logic               sub_wr;
  logic               rd_strobe;
  logic [1:0]         en_q;
  engine_idx_t        sel_q;
  logic [NrCores-1:0] evt_q;
  logic [NrCores-1:0] sel_evt;
  logic [NrCores-1:0] clr_mask;
  logic               rd_sub_q;
  engine_idx_t        rd_eng_q;
  logic [DW-1:0]      sub_rdata_q;

  assign ofs       = ctrl_addr_i[OfsW-1:0];
  assign eng_sel   = engine_idx_t'(ctrl_addr_i[OfsW]);
  assign sub_hit   = ofs inside {`REG_EVT_CLR, `REG_MUX_SEL, `REG_ENABLE};
  assign sub_wr    = ctrl_req_i & ctrl_we_i & sub_hit;
  assign rd_strobe = ctrl_req_i & ~ctrl_we_i;

  // Engine accesses carry only the byte offset
  always_comb begin
    eng_req_o = '0;
    if (ctrl_req_i && !sub_hit) begin
      eng_req_o[eng_sel] = 1'b1;
    end
  end

  assign eng_we_o    = ctrl_we_i;
  assign eng_addr_o  = ofs;
  assign eng_wdata_o = ctrl_wdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q  <= '0;
      sel_q <= '0;
    end else begin
      if (sub_wr && ofs == `REG_ENABLE) begin
        en_q <= ctrl_wdata_i[1:0];
      end
      if (sub_wr && ofs == `REG_MUX_SEL) begin
        sel_q <= engine_idx_t'(ctrl_wdata_i[0]);
      end
    end
  end

  assign eng_en_o  = en_q;
  assign mux_sel_o = sel_q;

  // Only the engine that owns the memory port raises events
  assign sel_evt = sel_q ? eng1_evt_i : eng0_evt_i;

  always_comb begin
    for (int i = 0; i < NrCores; i++) begin
      clr_mask[i] = sub_wr && ofs == `REG_EVT_CLR && ctrl_wdata_i == (DW'(1) << i);
    end
  end

  // A new event beats a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_q <= '0;
    end else begin
      evt_q <= sel_evt | (evt_q & ~clr_mask);
    end
  end

  assign hwpe_evt_o = evt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_rvalid_o <= 1'b0;
      rd_sub_q      <= 1'b0;
      rd_eng_q      <= '0;
    end else begin
      ctrl_rvalid_o <= rd_strobe;
      if (rd_strobe) begin
        rd_sub_q <= sub_hit;
        rd_eng_q <= eng_sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_strobe) begin
      case (ofs)
        `REG_EVT_CLR: sub_rdata_q <= DW'(evt_q);
        `REG_MUX_SEL: sub_rdata_q <= DW'(sel_q);
        `REG_ENABLE:  sub_rdata_q <= DW'(en_q);
        default:      sub_rdata_q <= '0;
      endcase
    end
  end

  // Engines answer one cycle after their strobe
  assign ctrl_rdata_o = rd_sub_q ? sub_rdata_q : (rd_eng_q ? eng1_rdata_i : eng0_rdata_i);

endmodule

//--- datamover/datamover_engine.sv
// ********************************************************************
// Datamover engine, copies a block of words from source to destination
// Programmed through its register port, signals the end by an event
// ********************************************************************
`timescale 1ns/100ps
`include "hwpe_sub_cfg.svh"

module datamover_engine (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        en_i,
  input  logic                        reg_req_i,
  input  logic                        reg_we_i,
  input  logic [`HWPE_CTRL_AW-2:0]    reg_addr_i,
  input  logic [`HWPE_DW-1:0]         reg_wdata_i,
  output logic [`HWPE_DW-1:0]         reg_rdata_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic [`HWPE_AW-1:0]         mem_addr_o,
  output logic [`HWPE_DW-1:0]         mem_wdata_o,
  input  logic                        mem_rvalid_i,
  input  logic [`HWPE_DW-1:0]         mem_rdata_i,
  output logic [`HWPE_NR_CORES-1:0]   evt_o
);
  import hwpe_sub_pkg::*;

  localparam int unsigned DW      = `HWPE_DW;
  localparam int unsigned AW      = `HWPE_AW;
  localparam int unsigned NrCores = `HWPE_NR_CORES;
  localparam int unsigned CoreW   = $clog2(NrCores);

  engine_state_e    state_q;
  engine_state_e    state_d;
  logic [AW-1:0]    src_q;
  logic [AW-1:0]    dst_q;
  logic [AW-1:0]    len_q;
  logic [AW-1:0]    idx_q;
  logic [CoreW-1:0] core_q;
  logic [DW-1:0]    data_q;
  logic             wr_en;
  logic             start;

  // A disabled engine ignores register writes
  assign wr_en = en_i & reg_req_i & reg_we_i;
  assign start = wr_en && reg_addr_i == `REG_TRIGGER && state_q == IDLE && len_q != '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q  <= '0;
      dst_q  <= '0;
      len_q  <= '0;
      core_q <= '0;
    end else if (wr_en) begin
      case (reg_addr_i)
        `REG_SRC:  src_q  <= reg_wdata_i[AW-1:0];
        `REG_DST:  dst_q  <= reg_wdata_i[AW-1:0];
        `REG_LEN:  len_q  <= reg_wdata_i[AW-1:0];
        `REG_CORE: core_q <= reg_wdata_i[CoreW-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_req_i && !reg_we_i) begin
      case (reg_addr_i)
        `REG_STATUS: reg_rdata_o <= DW'(state_q != IDLE);
        `REG_SRC:    reg_rdata_o <= DW'(src_q);
        `REG_DST:    reg_rdata_o <= DW'(dst_q);
        `REG_LEN:    reg_rdata_o <= DW'(len_q);
        `REG_CORE:   reg_rdata_o <= DW'(core_q);
        default:     reg_rdata_o <= '0;
      endcase
    end
  end

  // Read, wait for data, write: three cycles per word
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start) state_d = READ;
      READ:    state_d = WAIT;
      WAIT:    if (mem_rvalid_i) state_d = WRITE;
      WRITE:   state_d = (idx_q == len_q - 1'b1) ? DONE : READ;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else if (en_i) begin
      state_q <= state_d;
      if (start) begin
        idx_q <= '0;
      end else if (state_q == WRITE) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i && state_q == WAIT && mem_rvalid_i) begin
      data_q <= mem_rdata_i;
    end
  end

  assign mem_req_o   = en_i & (state_q == READ || state_q == WRITE);
  assign mem_we_o    = state_q == WRITE;
  assign mem_addr_o  = (state_q == WRITE) ? dst_q + idx_q : src_q + idx_q;
  assign mem_wdata_o = data_q;

  assign evt_o = (en_i && state_q == DONE) ? NrCores'(1) << core_q : '0;

endmodule

//--- scaler/scaler_engine.sv
// ********************************************************************
// Scaler engine, writes each source word times a programmed factor
// Same register port and sequencing as the datamover
// ********************************************************************
`timescale 1ns/100ps
`include "hwpe_sub_cfg.svh"

module scaler_engine (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        en_i,
  input  logic                        reg_req_i,
  input  logic                        reg_we_i,
  input  logic [`HWPE_CTRL_AW-2:0]    reg_addr_i,
  input  logic [`HWPE_DW-1:0]         reg_wdata_i,
  output logic [`HWPE_DW-1:0]         reg_rdata_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic [`HWPE_AW-1:0]         mem_addr_o,
  output logic [`HWPE_DW-1:0]         mem_wdata_o,
  input  logic                        mem_rvalid_i,
  input  logic [`HWPE_DW-1:0]         mem_rdata_i,
  output logic [`HWPE_NR_CORES-1:0]   evt_o
);
  import hwpe_sub_pkg::*;

  localparam int unsigned DW      = `HWPE_DW;
  localparam int unsigned AW      = `HWPE_AW;
  localparam int unsigned NrCores = `HWPE_NR_CORES;
  localparam int unsigned CoreW   = $clog2(NrCores);

  engine_state_e    state_q;
  engine_state_e    state_d;
  logic [AW-1:0]    src_q;
  logic [AW-1:0]    dst_q;
  logic [AW-1:0]    len_q;
  logic [AW-1:0]    idx_q;
  logic [CoreW-1:0] core_q;
  logic [DW-1:0]    factor_q;
  logic [DW-1:0]    data_q;
  logic             wr_en;
  logic             start;

  assign wr_en = en_i & reg_req_i & reg_we_i;
  assign start = wr_en && reg_addr_i == `REG_TRIGGER && state_q == IDLE && len_q != '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
      core_q   <= '0;
      factor_q <= '0;
    end else if (wr_en) begin
      case (reg_addr_i)
        `REG_SRC:    src_q    <= reg_wdata_i[AW-1:0];
        `REG_DST:    dst_q    <= reg_wdata_i[AW-1:0];
        `REG_LEN:    len_q    <= reg_wdata_i[AW-1:0];
        `REG_CORE:   core_q   <= reg_wdata_i[CoreW-1:0];
        `REG_FACTOR: factor_q <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_req_i && !reg_we_i) begin
      case (reg_addr_i)
        `REG_STATUS: reg_rdata_o <= DW'(state_q != IDLE);
        `REG_SRC:    reg_rdata_o <= DW'(src_q);
        `REG_DST:    reg_rdata_o <= DW'(dst_q);
        `REG_LEN:    reg_rdata_o <= DW'(len_q);
        `REG_CORE:   reg_rdata_o <= DW'(core_q);
        `REG_FACTOR: reg_rdata_o <= factor_q;
        default:     reg_rdata_o <= '0;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start) state_d = READ;
      READ:    state_d = WAIT;
      WAIT:    if (mem_rvalid_i) state_d = WRITE;
      WRITE:   state_d = (idx_q == len_q - 1'b1) ? DONE : READ;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else if (en_i) begin
      state_q <= state_d;
      if (start) begin
        idx_q <= '0;
      end else if (state_q == WRITE) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // Product is truncated to the data width
  always_ff @(posedge clk_i) begin
    if (en_i && state_q == WAIT && mem_rvalid_i) begin
      data_q <= mem_rdata_i * factor_q;
    end
  end

  assign mem_req_o   = en_i & (state_q == READ || state_q == WRITE);
  assign mem_we_o    = state_q == WRITE;
  assign mem_addr_o  = (state_q == WRITE) ? dst_q + idx_q : src_q + idx_q;
  assign mem_wdata_o = data_q;

  assign evt_o = (en_i && state_q == DONE) ? NrCores'(1) << core_q : '0;

endmodule

//--- source/mem_static_mux.sv
// ********************************************************************
// Static two-to-one mux of the engines onto the memory port
// Read data follows the select that was active at the read strobe
// ********************************************************************
`timescale 1ns/100ps
`include "hwpe_sub_cfg.svh"

module mem_static_mux (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  hwpe_sub_pkg::engine_idx_t    sel_i,
  input  logic [1:0]                   in_req_i,
  input  logic [1:0]                   in_we_i,
  input  logic [1:0][`HWPE_AW-1:0]     in_addr_i,
  input  logic [1:0][`HWPE_DW-1:0]     in_wdata_i,
  output logic                         out_req_o,
  output logic                         out_we_o,
  output logic [`HWPE_AW-1:0]          out_addr_o,
  output logic [`HWPE_DW-1:0]          out_wdata_o,
  input  logic                         mem_rvalid_i,
  input  logic [`HWPE_DW-1:0]          mem_rdata_i,
  output logic [1:0]                   in_rvalid_o,
  output logic [`HWPE_DW-1:0]          in_rdata_o
);
  import hwpe_sub_pkg::*;

  engine_idx_t rsel_q;

  assign out_req_o   = in_req_i[sel_i];
  assign out_we_o    = in_we_i[sel_i];
  assign out_addr_o  = in_addr_i[sel_i];
  assign out_wdata_o = in_wdata_i[sel_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsel_q <= '0;
    end else if (out_req_o && !out_we_o) begin
      rsel_q <= sel_i;
    end
  end

  always_comb begin
    in_rvalid_o         = '0;
    in_rvalid_o[rsel_q] = mem_rvalid_i;
  end

  assign in_rdata_o = mem_rdata_i;

endmodule

//--- source/hwpe_subsystem.sv
// ********************************************************************
// Accelerator subsystem top with datamover and scaler engines
// One control port in, one shared memory port out
// ********************************************************************
`timescale 1ns/100ps
`include "hwpe_sub_cfg.svh"

module hwpe_subsystem (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        ctrl_req_i,
  input  logic                        ctrl_we_i,
  input  logic [`HWPE_CTRL_AW-1:0]    ctrl_addr_i,
  input  logic [`HWPE_DW-1:0]         ctrl_wdata_i,
  output logic                        ctrl_rvalid_o,
  output logic [`HWPE_DW-1:0]         ctrl_rdata_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic [`HWPE_AW-1:0]         mem_addr_o,
  output logic [`HWPE_DW-1:0]         mem_wdata_o,
  input  logic                        mem_rvalid_i,
  input  logic [`HWPE_DW-1:0]         mem_rdata_i,
  output logic [`HWPE_NR_CORES-1:0]   hwpe_evt_o
);
  import hwpe_sub_pkg::*;

  logic [1:0]                      eng_req;
  logic                            eng_we;
  logic [`HWPE_CTRL_AW-2:0]        eng_addr;
  logic [`HWPE_DW-1:0]             eng_wdata;
  logic [`HWPE_DW-1:0]             eng0_rdata;
  logic [`HWPE_DW-1:0]             eng1_rdata;
  logic [`HWPE_NR_CORES-1:0]       eng0_evt;
  logic [`HWPE_NR_CORES-1:0]       eng1_evt;
  logic [1:0]                      eng_en;
  engine_idx_t                     mux_sel;
  logic [1:0]                      eng_mem_req;
  logic [1:0]                      eng_mem_we;
  logic [1:0][`HWPE_AW-1:0]        eng_mem_addr;
  logic [1:0][`HWPE_DW-1:0]        eng_mem_wdata;
  logic [1:0]                      eng_mem_rvalid;
  logic [`HWPE_DW-1:0]             eng_mem_rdata;

  hwpe_ctrl_router router_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .ctrl_req_i    ( ctrl_req_i    ),
    .ctrl_we_i     ( ctrl_we_i     ),
    .ctrl_addr_i   ( ctrl_addr_i   ),
    .ctrl_wdata_i  ( ctrl_wdata_i  ),
    .ctrl_rvalid_o ( ctrl_rvalid_o ),
    .ctrl_rdata_o  ( ctrl_rdata_o  ),
    .eng_req_o     ( eng_req       ),
    .eng_we_o      ( eng_we        ),
    .eng_addr_o    ( eng_addr      ),
    .eng_wdata_o   ( eng_wdata     ),
    .eng0_rdata_i  ( eng0_rdata    ),
    .eng1_rdata_i  ( eng1_rdata    ),
    .eng0_evt_i    ( eng0_evt      ),
    .eng1_evt_i    ( eng1_evt      ),
    .eng_en_o      ( eng_en        ),
    .mux_sel_o     ( mux_sel       ),
    .hwpe_evt_o    ( hwpe_evt_o    )
  );

  // Engine 0
  datamover_engine datamover_inst (
    .clk_i        ( clk_i             ),
    .rst_ni       ( rst_ni            ),
    .en_i         ( eng_en[0]         ),
    .reg_req_i    ( eng_req[0]        ),
    .reg_we_i     ( eng_we            ),
    .reg_addr_i   ( eng_addr          ),
    .reg_wdata_i  ( eng_wdata         ),
    .reg_rdata_o  ( eng0_rdata        ),
    .mem_req_o    ( eng_mem_req[0]    ),
    .mem_we_o     ( eng_mem_we[0]     ),
    .mem_addr_o   ( eng_mem_addr[0]   ),
    .mem_wdata_o  ( eng_mem_wdata[0]  ),
    .mem_rvalid_i ( eng_mem_rvalid[0] ),
    .mem_rdata_i  ( eng_mem_rdata     ),
    .evt_o        ( eng0_evt          )
  );

  // Engine 1
  scaler_engine scaler_inst (
    .clk_i        ( clk_i             ),
    .rst_ni       ( rst_ni            ),
    .en_i         ( eng_en[1]         ),
    .reg_req_i    ( eng_req[1]        ),
    .reg_we_i     ( eng_we            ),
    .reg_addr_i   ( eng_addr          ),
    .reg_wdata_i  ( eng_wdata         ),
    .reg_rdata_o  ( eng1_rdata        ),
    .mem_req_o    ( eng_mem_req[1]    ),
    .mem_we_o     ( eng_mem_we[1]     ),
    .mem_addr_o   ( eng_mem_addr[1]   ),
    .mem_wdata_o  ( eng_mem_wdata[1]  ),
    .mem_rvalid_i ( eng_mem_rvalid[1] ),
    .mem_rdata_i  ( eng_mem_rdata     ),
    .evt_o        ( eng1_evt          )
  );

  mem_static_mux mux_inst (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .sel_i        ( mux_sel        ),
    .in_req_i     ( eng_mem_req    ),
    .in_we_i      ( eng_mem_we     ),
    .in_addr_i    ( eng_mem_addr   ),
    .in_wdata_i   ( eng_mem_wdata  ),
    .out_req_o    ( mem_req_o      ),
    .out_we_o     ( mem_we_o       ),
    .out_addr_o   ( mem_addr_o     ),
    .out_wdata_o  ( mem_wdata_o    ),
    .mem_rvalid_i ( mem_rvalid_i   ),
    .mem_rdata_i  ( mem_rdata_i    ),
    .in_rvalid_o  ( eng_mem_rvalid ),
    .in_rdata_o   ( eng_mem_rdata  )
  );

endmodule

//--- verification/hwpe_subsystem_props.sv
// ********************************************************************
// Control, memory port and event assertions of the subsystem
// Bound to every hwpe_subsystem instance by the bind below
// ********************************************************************
`timescale 1ns/100ps
`include "hwpe_sub_cfg.svh"

module hwpe_subsystem_props (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          ctrl_req_i,
  input logic                          ctrl_we_i,
  input logic [`HWPE_CTRL_AW-1:0]      ctrl_addr_i,
  input logic [`HWPE_DW-1:0]           ctrl_wdata_i,
  input logic                          ctrl_rvalid_i,
  input logic                          mem_req_i,
  input logic [`HWPE_NR_CORES-1:0]     hwpe_evt_i,
  input logic [1:0]                    eng_en_i,
  input hwpe_sub_pkg::engine_idx_t     mux_sel_i,
  input logic [`HWPE_NR_CORES-1:0]     eng0_evt_i,
  input logic [`HWPE_NR_CORES-1:0]     eng1_evt_i,
  input hwpe_sub_pkg::engine_state_e   eng0_state_i,
  input hwpe_sub_pkg::engine_state_e   eng1_state_i
);
  import hwpe_sub_pkg::*;

  localparam int unsigned DW      = `HWPE_DW;
  localparam int unsigned NrCores = `HWPE_NR_CORES;

  logic               rd_strobe;
  logic [NrCores-1:0] clr_hit;

  assign rd_strobe = ctrl_req_i & ~ctrl_we_i;

  always_comb begin
    for (int i = 0; i < NrCores; i++) begin
      clr_hit[i] = ctrl_req_i && ctrl_we_i && ctrl_addr_i[7:0] == `REG_EVT_CLR &&
                   ctrl_wdata_i == (DW'(1) << i);
    end
  end

  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_strobe |=> ctrl_rvalid_i) else $error("read strobe without rvalid one cycle later");

  rvalid_only_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_rvalid_i |-> $past(rd_strobe)) else $error("rvalid without a read strobe before it");

  mem_req_enabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i |-> eng_en_i[mux_sel_i]) else $error("memory request from a disabled engine");

  // An event bit only drops on its exact one-hot clear
  for (genvar i = 0; i < NrCores; i++) begin : gen_evt_hold
    evt_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      hwpe_evt_i[i] && !clr_hit[i] |=> hwpe_evt_i[i])
      else $error("event bit %0d dropped without a clear", i);
  end

  eng0_evt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(eng0_evt_i) && (eng0_evt_i == '0 || eng0_state_i == DONE))
    else $error("datamover event is not one-hot or not in DONE");

  eng1_evt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(eng1_evt_i) && (eng1_evt_i == '0 || eng1_state_i == DONE))
    else $error("scaler event is not one-hot or not in DONE");

endmodule

bind hwpe_subsystem hwpe_subsystem_props props_inst (
  .clk_i         ( clk_i                  ),
  .rst_ni        ( rst_ni                 ),
  .ctrl_req_i    ( ctrl_req_i             ),
  .ctrl_we_i     ( ctrl_we_i              ),
  .ctrl_addr_i   ( ctrl_addr_i            ),
  .ctrl_wdata_i  ( ctrl_wdata_i           ),
  .ctrl_rvalid_i ( ctrl_rvalid_o          ),
  .mem_req_i     ( mem_req_o              ),
  .hwpe_evt_i    ( hwpe_evt_o             ),
  .eng_en_i      ( eng_en                 ),
  .mux_sel_i     ( mux_sel                ),
  .eng0_evt_i    ( eng0_evt               ),
  .eng1_evt_i    ( eng1_evt               ),
  .eng0_state_i  ( datamover_inst.state_q ),
  .eng1_state_i  ( scaler_inst.state_q    )
);

//--- verification/hwpe_subsystem_tb.sv
// ********************************************************************
// Testbench of the accelerator subsystem with a one-cycle memory model
// Runs readback, copy, scale, event and enable tests on the top level
// ********************************************************************
`timescale 1ns/100ps
`include "hwpe_sub_cfg.svh"

module hwpe_subsystem_tb;

  localparam int unsigned NrTests        = 5;
  localparam int unsigned TotalWords     = 44;
  localparam int unsigned WatchdogCycles = 3 * TotalWords + 200 * NrTests;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        ctrl_req_i;
  logic                        ctrl_we_i;
  logic [`HWPE_CTRL_AW-1:0]    ctrl_addr_i;
  logic [`HWPE_DW-1:0]         ctrl_wdata_i;
  logic                        ctrl_rvalid_o;
  logic [`HWPE_DW-1:0]         ctrl_rdata_o;
  logic                        mem_req_o;
  logic                        mem_we_o;
  logic [`HWPE_AW-1:0]         mem_addr_o;
  logic [`HWPE_DW-1:0]         mem_wdata_o;
  logic                        mem_rvalid_i;
  logic [`HWPE_DW-1:0]         mem_rdata_i;
  logic [`HWPE_NR_CORES-1:0]   hwpe_evt_o;

  logic [31:0] mem [0:1023];
  integer      seed;
  int          n_checks;
  int          n_errors;
  int          mem_req_count;
  int          count_before;
  logic [31:0] factor;
  // Sampled memory request
  logic        rd_hit;
  logic        wr_hit;
  logic [9:0]  mem_idx;
  logic [31:0] wdata_s;
  // Job under test as seen by the compare process
  logic        check_req;
  string       job_name;
  logic        job_eng;
  logic [15:0] job_src;
  logic [15:0] job_dst;
  logic [15:0] job_len;
  logic [1:0]  job_core;
  logic [31:0] job_factor;

  hwpe_subsystem hwpe_subsystem_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .ctrl_req_i    ( ctrl_req_i    ),
    .ctrl_we_i     ( ctrl_we_i     ),
    .ctrl_addr_i   ( ctrl_addr_i   ),
    .ctrl_wdata_i  ( ctrl_wdata_i  ),
    .ctrl_rvalid_o ( ctrl_rvalid_o ),
    .ctrl_rdata_o  ( ctrl_rdata_o  ),
    .mem_req_o     ( mem_req_o     ),
    .mem_we_o      ( mem_we_o      ),
    .mem_addr_o    ( mem_addr_o    ),
    .mem_wdata_o   ( mem_wdata_o   ),
    .mem_rvalid_i  ( mem_rvalid_i  ),
    .mem_rdata_i   ( mem_rdata_i   ),
    .hwpe_evt_o    ( hwpe_evt_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Memory answers a read one cycle after the strobe
  always begin
    @(negedge clk_i);
    rd_hit  = mem_req_o === 1'b1 && mem_we_o === 1'b0;
    wr_hit  = mem_req_o === 1'b1 && mem_we_o === 1'b1;
    mem_idx = mem_addr_o[9:0];
    wdata_s = mem_wdata_o;
    if (mem_req_o === 1'b1) begin
      mem_req_count++;
    end
    @(posedge clk_i);
    #1;
    if (wr_hit) begin
      mem[mem_idx] = wdata_s;
    end
    mem_rvalid_i = rd_hit;
    mem_rdata_i  = rd_hit ? mem[mem_idx] : '0;
  end

  function automatic logic [31:0] expected_word(input logic eng, input logic [31:0] src_word,
                                                input logic [31:0] mult);
    logic [63:0] product;
    product = 64'(src_word) * 64'(mult);
    return eng ? product[31:0] : src_word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic ctrl_write(input logic [8:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    #1;
    ctrl_req_i   = 1'b1;
    ctrl_we_i    = 1'b1;
    ctrl_addr_i  = addr;
    ctrl_wdata_i = data;
    @(posedge clk_i);
    #1;
    ctrl_req_i = 1'b0;
    ctrl_we_i  = 1'b0;
  endtask

  task automatic read_check(input string name, input logic [8:0] addr,
                            input logic [31:0] expected);
    @(posedge clk_i);
    #1;
    ctrl_req_i  = 1'b1;
    ctrl_we_i   = 1'b0;
    ctrl_addr_i = addr;
    @(posedge clk_i);
    #1;
    ctrl_req_i = 1'b0;
    check_value({name, " rvalid"}, 32'd1, 32'(ctrl_rvalid_o));
    check_value(name, expected, ctrl_rdata_o);
  endtask

  task automatic program_job(input logic eng, input logic [15:0] src, input logic [15:0] dst,
                             input logic [15:0] len, input logic [1:0] core,
                             input logic [31:0] mult);
    job_eng    = eng;
    job_src    = src;
    job_dst    = dst;
    job_len    = len;
    job_core   = core;
    job_factor = mult;
    ctrl_write({eng, `REG_SRC}, 32'(src));
    ctrl_write({eng, `REG_DST}, 32'(dst));
    ctrl_write({eng, `REG_LEN}, 32'(len));
    ctrl_write({eng, `REG_CORE}, 32'(core));
    if (eng) begin
      ctrl_write({eng, `REG_FACTOR}, mult);
    end
  endtask

  // Waits for the completion event and hands the job to the compare process
  task automatic finish_job(input string name);
    do begin
      @(posedge clk_i);
      #1;
    end while (hwpe_evt_o[job_core] !== 1'b1);
    job_name  = name;
    check_req = 1'b1;
    wait (!check_req);
    check_value({name, " event"}, 32'(1) << job_core, 32'(hwpe_evt_o));
  endtask

  initial begin
    forever begin
      wait (check_req);
      for (int i = 0; i < job_len; i++) begin
        check_value($sformatf("%s word %0d", job_name, i),
                    expected_word(job_eng, mem[(job_src + i) % 1024], job_factor),
                    mem[(job_dst + i) % 1024]);
      end
      check_req = 1'b0;
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    seed          = 1945;
    n_checks      = 0;
    n_errors      = 0;
    mem_req_count = 0;
    check_req     = 1'b0;
    rst_ni        = 1'b0;
    ctrl_req_i    = 1'b0;
    ctrl_we_i     = 1'b0;
    ctrl_addr_i   = '0;
    ctrl_wdata_i  = '0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = $random(seed);
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Register readback
    ctrl_write(`REG_ENABLE, 32'h3);
    read_check("enable", `REG_ENABLE, 32'h3);
    read_check("enable via engine 1 half", {1'b1, `REG_ENABLE}, 32'h3);
    ctrl_write(`REG_MUX_SEL, 32'h1);
    read_check("mux select", `REG_MUX_SEL, 32'h1);
    ctrl_write(`REG_MUX_SEL, 32'h0);
    ctrl_write(`REG_SRC, 32'h1234);
    read_check("engine 0 source", `REG_SRC, 32'h1234);
    ctrl_write({1'b1, `REG_LEN}, 32'h0021);
    read_check("engine 1 length", {1'b1, `REG_LEN}, 32'h0021);
    ctrl_write({1'b1, `REG_FACTOR}, 32'hdeadbeef);
    read_check("engine 1 factor", {1'b1, `REG_FACTOR}, 32'hdeadbeef);
    read_check("engine 0 factor unused", `REG_FACTOR, 32'h0);
    read_check("unused offset", {1'b1, 8'h40}, 32'h0);
    read_check("event vector", `REG_EVT_CLR, 32'h0);

    // Datamover copy and clear of its event
    program_job(1'b0, 16'h010, 16'h100, 16'd16, 2'd2, 32'h0);
    ctrl_write(`REG_TRIGGER, 32'h1);
    finish_job("datamover copy");
    read_check("event vector after copy", `REG_EVT_CLR, 32'h4);
    ctrl_write(`REG_EVT_CLR, 32'h6);
    check_value("clear with non one-hot value", 32'h4, 32'(hwpe_evt_o));
    ctrl_write(`REG_EVT_CLR, 32'h4);
    check_value("clear with one-hot value", 32'h0, 32'(hwpe_evt_o));

    // Scaler job with a random factor
    factor = $random(seed);
    ctrl_write(`REG_MUX_SEL, 32'h1);
    program_job(1'b1, 16'h040, 16'h200, 16'd16, 2'd1, factor);
    ctrl_write({1'b1, `REG_TRIGGER}, 32'h1);
    finish_job("scaler job");
    ctrl_write(`REG_EVT_CLR, 32'h2);

    // Trigger while disabled starts nothing
    ctrl_write(`REG_MUX_SEL, 32'h0);
    program_job(1'b0, 16'h080, 16'h300, 16'd8, 2'd3, 32'h0);
    ctrl_write(`REG_ENABLE, 32'h2);
    count_before = mem_req_count;
    ctrl_write(`REG_TRIGGER, 32'h1);
    read_check("busy while disabled", `REG_STATUS, 32'h0);
    check_value("traffic while disabled", 32'(count_before), 32'(mem_req_count));
    ctrl_write(`REG_ENABLE, 32'h3);
    ctrl_write(`REG_TRIGGER, 32'h1);
    finish_job("copy after enable");
    ctrl_write(`REG_EVT_CLR, 32'h8);

    // Unselected engine never completes its job and stays stuck to the end
    program_job(1'b1, 16'h0C0, 16'h380, 16'd4, 2'd0, 32'h3);
    count_before = mem_req_count;
    ctrl_write({1'b1, `REG_TRIGGER}, 32'h1);
    repeat (3 * 4 + 20) @(posedge clk_i);
    #1;
    check_value("unselected engine traffic", 32'(count_before), 32'(mem_req_count));
    check_value("unselected engine event", 32'h0, 32'(hwpe_evt_o));

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+common
common/hwpe_sub_pkg.sv
source/hwpe_ctrl_router.sv
datamover/datamover_engine.sv
scaler/scaler_engine.sv
source/mem_static_mux.sv
source/hwpe_subsystem.sv
verification/hwpe_subsystem_props.sv
verification/hwpe_subsystem_tb.sv

//--- Bender.yml
package:
  name: hwpe_subsystem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/hwpe_sub_pkg.sv
      - source/hwpe_ctrl_router.sv
      - datamover/datamover_engine.sv
      - scaler/scaler_engine.sv
      - source/mem_static_mux.sv
      - source/hwpe_subsystem.sv
      - target: test
        files:
          - verification/hwpe_subsystem_props.sv
          - verification/hwpe_subsystem_tb.sv
